//--- hw/canProtocolPkg.sv
package canProtocolPkg;

  // ----------------------------------------
  // Frame field lengths
  // ----------------------------------------
  localparam int IdBaseBits        = 11;  // Standard identifier
  localparam int IdExtBits         = 18;  // Identifier extension
  localparam int DlcBits           = 4;   // Data length code
  localparam int CrcBits           = 15;  // CRC sequence
  localparam int EofBits           = 7;   // End of frame, all recessive
  localparam int MaxDataBytes      = 8;   // DLC 9..15 still means 8 bytes
  localparam int IdleRecessiveBits = 11;  // Bus idle after an error
  localparam int StuffRunLimit     = 5;   // Equal bits before a stuff bit

  // ----------------------------------------
  // Field types
  // ----------------------------------------
  // Base identifier sits in the upper 11 bits
  typedef logic [IdBaseBits+IdExtBits-1:0] canId;

  typedef logic [DlcBits-1:0] canDlc;  // Raw code as received

  // First received byte in the top byte lane
  typedef logic [MaxDataBytes*8-1:0] canData;

  typedef logic [CrcBits-1:0] crcReg;

  // x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
  localparam crcReg CrcPoly = 15'h4599;

endpackage

//--- hw/canRxResultPkg.sv
package canRxResultPkg;

  // Outcome of one frame
  typedef enum logic [1:0] {
    statusOk,        // Frame complete and clean
    statusStuffErr,  // Six equal bits inside the stuffed region
    statusCrcErr,    // Nonzero remainder at CRC delimiter
    statusFormErr    // Dominant delimiter or EOF bit
  } rxStatus;

  // ----------------------------------------
  // Result queue sizing
  // ----------------------------------------
  localparam int QueueDepth  = 2;  // Records held while waiting for credit
  localparam int CreditWidth = 3;  // Credit counter, max 7 outstanding

endpackage

//--- hw/bitDestuffer.sv
`timescale 1ns/1ns

module bitDestuffer import canProtocolPkg::*;
(
  input  logic Clock_SP,
  input  logic rst,
  input  logic rxBit,
  input  logic bitStrobe,
  input  logic stuffEnable,
  output logic bitOut,
  output logic bitValid,
  output logic stuffErr
);

  logic                                 lastBit;   // Value of the current run
  logic [$clog2(StuffRunLimit+1)-1:0]   runCount;  // Length of the current run
  logic                                 runFull;

  assign runFull = (runCount == StuffRunLimit);  // Next bit is a stuff bit

  always_ff @(posedge Clock_SP)
  begin
    if (rst)
    begin
      bitValid <= 1'b0;
      stuffErr <= 1'b0;
      runCount <= '0;
      lastBit  <= 1'b1;  // Bus idles recessive
    end
    else
    begin
      bitValid <= 1'b0;  // Single-cycle pulses
      stuffErr <= 1'b0;
      if (bitStrobe)
      begin
        if (!stuffEnable)
        begin
          runCount <= 1;  // SOF seeds the first run
          lastBit  <= rxBit;
          bitValid <= 1'b1;
        end
        else if (runFull)
        begin
          runCount <= 1;  // Stuff bit opens the next run
          lastBit  <= rxBit;
          if (rxBit == lastBit)
            stuffErr <= 1'b1;  // Sixth equal bit
        end
        else if (rxBit == lastBit)
        begin
          runCount <= runCount + 1'b1;
          bitValid <= 1'b1;
        end
        else
        begin
          runCount <= 1;  // Edge restarts the run
          lastBit  <= rxBit;
          bitValid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge Clock_SP)
  begin
    if (bitStrobe)
      bitOut <= rxBit;  // Qualified by bitValid
  end

  // A dropped or faulty bit never reaches the decoder as data
  assert property (@(posedge Clock_SP) disable iff (rst)
    !(bitValid && stuffErr));

endmodule

//--- hw/crc15Checker.sv
`timescale 1ns/1ns

module crc15Checker import canProtocolPkg::*;
(
  input  logic Clock_SP,
  input  logic rst,
  input  logic crcBit,
  input  logic crcBitValid,
  input  logic crcClear,
  output logic crcZero
);

  crcReg crcState;  // Running remainder
  crcReg crcBase;   // Start value for this update
  crcReg crcNext;
  logic  feedback;

  always_comb
  begin
    crcBase  = crcClear ? '0 : crcState;  // SOF starts from zero
    feedback = crcBit ^ crcBase[CrcBits-1];
    crcNext  = {crcBase[CrcBits-2:0], 1'b0} ^ (feedback ? CrcPoly : '0);
  end

  always_ff @(posedge Clock_SP)
  begin
    if (rst)
      crcState <= '0;
    else if (crcBitValid)
      crcState <= crcNext;  // Shift one covered bit
    else if (crcClear)
      crcState <= '0;
  end

  // Zero once the received CRC has passed through
  assign crcZero = (crcState == '0);

endmodule

//--- hw/frameFieldDecoder.sv
`timescale 1ns/1ns

module frameFieldDecoder import canProtocolPkg::*, canRxResultPkg::*;
(
  input  logic    Clock_SP,
  input  logic    rst,
  input  logic    bitOut,
  input  logic    bitValid,
  input  logic    stuffErr,
  input  logic    crcZero,
  output logic    stuffEnable,
  output logic    crcBit,
  output logic    crcBitValid,
  output logic    crcClear,
  output logic    pushValid,
  output canId    pushId,
  output logic    pushIde,
  output logic    pushRtr,
  output canDlc   pushDlc,
  output canData  pushData,
  output rxStatus pushStatus
);

  typedef enum logic [3:0] {
    stIdle,      // Wait for dominant SOF
    stBaseId,
    stSrrRtr,    // RTR for standard, SRR for extended
    stIde,
    stExtId,
    stExtRtr,
    stReserved,  // r0, or r1 and r0
    stDlc,
    stData,
    stCrc,
    stCrcDelim,
    stAckSlot,   // Value not checked
    stAckDelim,
    stEof,
    stErrWait    // Count recessive bits back to idle
  } decState;

  decState    state;
  logic [6:0] bitCnt;     // Bit index inside the current field
  logic [3:0] dataBytes;  // DLC clipped to MaxDataBytes
  canDlc      dlcShift;   // DLC including the current bit
  logic       inFrame;
  logic       errNow;
  rxStatus    errCode;

  assign inFrame  = (state != stIdle) && (state != stErrWait);
  assign dlcShift = {pushDlc[DlcBits-2:0], bitOut};

  // ----------------------------------------
  // CRC checker feed
  // ----------------------------------------
  assign crcBit   = bitOut;
  assign crcClear = bitValid && (state == stIdle) && !bitOut;  // Restart on SOF

  always_comb
  begin
    case (state)
      stIdle:   crcBitValid = bitValid && !bitOut;  // SOF is covered
      stBaseId, stSrrRtr, stIde, stExtId, stExtRtr,
      stReserved, stDlc, stData, stCrc:
        crcBitValid = bitValid;  // Received CRC bits clear the remainder
      default:  crcBitValid = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Error detection
  // ----------------------------------------
  always_comb
  begin
    errNow  = 1'b0;
    errCode = statusOk;
    if (stuffErr && inFrame)
    begin
      errNow  = 1'b1;
      errCode = statusStuffErr;
    end
    else if (bitValid)
    begin
      case (state)
        stCrcDelim:
        begin
          if (!bitOut)
          begin
            errNow  = 1'b1;
            errCode = statusFormErr;  // Delimiter must be recessive
          end
          else if (!crcZero)
          begin
            errNow  = 1'b1;
            errCode = statusCrcErr;
          end
        end
        stAckDelim, stEof:
        begin
          if (!bitOut)
          begin
            errNow  = 1'b1;
            errCode = statusFormErr;
          end
        end
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Field FSM
  // ----------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (rst)
    begin
      state       <= stIdle;
      bitCnt      <= '0;
      stuffEnable <= 1'b0;
      pushValid   <= 1'b0;
    end
    else
    begin
      pushValid <= 1'b0;
      if (errNow)
      begin
        state       <= stErrWait;  // Abort and report
        bitCnt      <= '0;
        stuffEnable <= 1'b0;
        pushValid   <= 1'b1;
        pushStatus  <= errCode;
      end
      else if (bitValid)
      begin
        case (state)
          stIdle:
          begin
            if (!bitOut)
            begin
              state       <= stBaseId;
              bitCnt      <= '0;
              stuffEnable <= 1'b1;
              pushId      <= '0;  // Standard frames leave extension zero
              pushData    <= '0;  // Unused bytes read as zero
            end
          end
          stBaseId:
          begin
            pushId[IdBaseBits+IdExtBits-1:IdExtBits] <=
              {pushId[IdBaseBits+IdExtBits-2:IdExtBits], bitOut};
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == IdBaseBits - 1)
              state <= stSrrRtr;
          end
          stSrrRtr:
          begin
            pushRtr <= bitOut;  // Overwritten later if extended
            state   <= stIde;
          end
          stIde:
          begin
            pushIde <= bitOut;
            bitCnt  <= '0;
            state   <= bitOut ? stExtId : stReserved;
          end
          stExtId:
          begin
            pushId[IdExtBits-1:0] <= {pushId[IdExtBits-2:0], bitOut};
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == IdExtBits - 1)
              state <= stExtRtr;
          end
          stExtRtr:
          begin
            pushRtr <= bitOut;
            bitCnt  <= '0;
            state   <= stReserved;
          end
          stReserved:
          begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == {6'd0, pushIde})  // One bit standard, two extended
            begin
              bitCnt <= '0;
              state  <= stDlc;
            end
          end
          stDlc:
          begin
            pushDlc <= dlcShift;
            bitCnt  <= bitCnt + 1'b1;
            if (bitCnt == DlcBits - 1)
            begin
              bitCnt    <= '0;
              dataBytes <= (dlcShift > MaxDataBytes) ? 4'(MaxDataBytes) : dlcShift;
              state     <= (pushRtr || dlcShift == '0) ? stCrc : stData;
            end
          end
          stData:
          begin
            pushData[MaxDataBytes*8-1 - bitCnt] <= bitOut;  // MSB first
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == {dataBytes, 3'b000} - 7'd1)
            begin
              bitCnt <= '0;
              state  <= stCrc;
            end
          end
          stCrc:
          begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == CrcBits - 1)
              state <= stCrcDelim;
          end
          stCrcDelim:
          begin
            stuffEnable <= 1'b0;  // Stuffed region ends here
            state       <= stAckSlot;
          end
          stAckSlot:  state <= stAckDelim;
          stAckDelim:
          begin
            bitCnt <= '0;
            state  <= stEof;
          end
          stEof:
          begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == EofBits - 1)
            begin
              state      <= stIdle;  // Clean frame
              pushValid  <= 1'b1;
              pushStatus <= statusOk;
            end
          end
          stErrWait:
          begin
            bitCnt <= bitOut ? bitCnt + 1'b1 : '0;  // Dominant restarts count
            if (bitOut && bitCnt == IdleRecessiveBits - 1)
            begin
              bitCnt <= '0;
              state  <= stIdle;
            end
          end
          default: state <= stIdle;
        endcase
      end
    end
  end

  // Records come only from the last EOF bit or from an abort
  assert property (@(posedge Clock_SP) disable iff (rst)
    pushValid |-> (state == stErrWait && $past(state) != stErrWait) ||
                  ($past(state) == stEof && state == stIdle));

endmodule

//--- hw/frameResultQueue.sv
`timescale 1ns/1ns

module frameResultQueue import canProtocolPkg::*, canRxResultPkg::*;
(
  input  logic    Clock_SP,
  input  logic    rst,
  input  logic    pushValid,
  input  logic    resCredit,
  input  canId    pushId,
  input  logic    pushIde,
  input  logic    pushRtr,
  input  canDlc   pushDlc,
  input  canData  pushData,
  input  rxStatus pushStatus,
  output logic    resValid,
  output canId    resId,
  output logic    resIde,
  output logic    resRtr,
  output canDlc   resDlc,
  output canData  resData,
  output rxStatus resStatus,
  output logic    resOverflow
);

  // Record storage
  canId    idMem     [QueueDepth];
  logic    ideMem    [QueueDepth];
  logic    rtrMem    [QueueDepth];
  canDlc   dlcMem    [QueueDepth];
  canData  dataMem   [QueueDepth];
  rxStatus statusMem [QueueDepth];

  logic [$clog2(QueueDepth)-1:0]   wrPtr;
  logic [$clog2(QueueDepth)-1:0]   rdPtr;
  logic [$clog2(QueueDepth+1)-1:0] fillCount;
  logic [CreditWidth-1:0]          creditCnt;  // Slots granted by consumer
  logic                            full;
  logic                            popMem;     // Deliver oldest stored record
  logic                            bypass;     // Empty queue, deliver push directly
  logic                            writeMem;
  logic                            spend;

  assign full     = (fillCount == QueueDepth);
  assign popMem   = (fillCount != '0) && (creditCnt != '0);
  assign bypass   = (fillCount == '0) && (creditCnt != '0) && pushValid;
  assign writeMem = pushValid && !bypass && (!full || popMem);  // Pop frees a slot
  assign spend    = popMem || bypass;

  // ----------------------------------------
  // Storage and output record
  // ----------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (writeMem)
    begin
      idMem[wrPtr]     <= pushId;
      ideMem[wrPtr]    <= pushIde;
      rtrMem[wrPtr]    <= pushRtr;
      dlcMem[wrPtr]    <= pushDlc;
      dataMem[wrPtr]   <= pushData;
      statusMem[wrPtr] <= pushStatus;
    end
    if (bypass)
    begin
      resId     <= pushId;  // One-cycle path when idle
      resIde    <= pushIde;
      resRtr    <= pushRtr;
      resDlc    <= pushDlc;
      resData   <= pushData;
      resStatus <= pushStatus;
    end
    else if (popMem)
    begin
      resId     <= idMem[rdPtr];
      resIde    <= ideMem[rdPtr];
      resRtr    <= rtrMem[rdPtr];
      resDlc    <= dlcMem[rdPtr];
      resData   <= dataMem[rdPtr];
      resStatus <= statusMem[rdPtr];
    end
  end

  // ----------------------------------------
  // Pointers, fill level, credit
  // ----------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (rst)
    begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      fillCount   <= '0;
      creditCnt   <= '0;
      resValid    <= 1'b0;
      resOverflow <= 1'b0;
    end
    else
    begin
      resValid  <= spend;  // One pulse per record
      creditCnt <= creditCnt + resCredit - spend;
      if (writeMem)
        wrPtr <= (wrPtr == QueueDepth - 1) ? '0 : wrPtr + 1'b1;
      if (popMem)
        rdPtr <= (rdPtr == QueueDepth - 1) ? '0 : rdPtr + 1'b1;
      if (writeMem && !popMem)
        fillCount <= fillCount + 1'b1;
      else if (popMem && !writeMem)
        fillCount <= fillCount - 1'b1;
      if (pushValid && full && !popMem)
        resOverflow <= 1'b1;  // Sticky, new record lost
    end
  end

  // Consumer never grants past the counter range
  assert property (@(posedge Clock_SP) disable iff (rst)
    !(creditCnt == '1 && resCredit && !spend));

  // Every delivered record was paid for
  assert property (@(posedge Clock_SP) disable iff (rst)
    resValid |-> $past(creditCnt) != '0);

endmodule

//--- hw/canRxTop.sv
`timescale 1ns/1ns

module canRxTop import canProtocolPkg::*, canRxResultPkg::*;
(
  input  logic    Clock_SP,
  input  logic    rst,
  input  logic    rxBit,
  input  logic    bitStrobe,
  input  logic    resCredit,
  output logic    resValid,
  output canId    resId,
  output logic    resIde,
  output logic    resRtr,
  output canDlc   resDlc,
  output canData  resData,
  output rxStatus resStatus,
  output logic    resOverflow
);

  // Destuffer to decoder
  logic    bitOut;
  logic    bitValid;
  logic    stuffErr;
  logic    stuffEnable;

  // Decoder to CRC checker
  logic    crcBit;
  logic    crcBitValid;
  logic    crcClear;
  logic    crcZero;

  // Decoder to result queue
  logic    pushValid;
  canId    pushId;
  logic    pushIde;
  logic    pushRtr;
  canDlc   pushDlc;
  canData  pushData;
  rxStatus pushStatus;

  bitDestuffer bitDestuffer_i (
    .Clock_SP    (Clock_SP),
    .rst         (rst),
    .rxBit       (rxBit),
    .bitStrobe   (bitStrobe),
    .stuffEnable (stuffEnable),
    .bitOut      (bitOut),
    .bitValid    (bitValid),
    .stuffErr    (stuffErr)
  );

  frameFieldDecoder frameFieldDecoder_i (
    .Clock_SP    (Clock_SP),
    .rst         (rst),
    .bitOut      (bitOut),
    .bitValid    (bitValid),
    .stuffErr    (stuffErr),
    .crcZero     (crcZero),
    .stuffEnable (stuffEnable),
    .crcBit      (crcBit),
    .crcBitValid (crcBitValid),
    .crcClear    (crcClear),
    .pushValid   (pushValid),
    .pushId      (pushId),
    .pushIde     (pushIde),
    .pushRtr     (pushRtr),
    .pushDlc     (pushDlc),
    .pushData    (pushData),
    .pushStatus  (pushStatus)
  );

  crc15Checker crc15Checker_i (
    .Clock_SP    (Clock_SP),
    .rst         (rst),
    .crcBit      (crcBit),
    .crcBitValid (crcBitValid),
    .crcClear    (crcClear),
    .crcZero     (crcZero)
  );

  frameResultQueue frameResultQueue_i (
    .Clock_SP    (Clock_SP),
    .rst         (rst),
    .pushValid   (pushValid),
    .resCredit   (resCredit),
    .pushId      (pushId),
    .pushIde     (pushIde),
    .pushRtr     (pushRtr),
    .pushDlc     (pushDlc),
    .pushData    (pushData),
    .pushStatus  (pushStatus),
    .resValid    (resValid),
    .resId       (resId),
    .resIde      (resIde),
    .resRtr      (resRtr),
    .resDlc      (resDlc),
    .resData     (resData),
    .resStatus   (resStatus),
    .resOverflow (resOverflow)
  );

endmodule

//--- sim/canRxTb.sv
`timescale 1ns/1ns

module canRxTb import canProtocolPkg::*, canRxResultPkg::*;
();

  // ----------------------------------------
  // Constants
  // ----------------------------------------
  localparam int          RecBits       = 101;      // id, ide, rtr, dlc, data, status
  localparam int          RecordTimeout = 4000;     // Cycles allowed for one record
  localparam int          QuietCycles   = 300;      // Window that must stay silent
  localparam int          IdleBits      = 12;       // Recessive bits after each frame
  localparam logic [14:0] CanCrcPoly    = 15'h4599; // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
  localparam int          ErrStuff      = 1;        // Stuff bit replaced by sixth equal bit
  localparam int          ErrCrc        = 2;        // Last CRC bit inverted
  localparam int          ErrAckDelim   = 3;        // Dominant ACK delimiter
  localparam int          ErrEofBit     = 4;        // Dominant fourth EOF bit

  logic    Clock_SP;
  logic    rst;
  logic    rxBit;
  logic    bitStrobe;
  logic    resCredit;
  logic    resValid;
  canId    resId;
  logic    resIde;
  logic    resRtr;
  canDlc   resDlc;
  canData  resData;
  rxStatus resStatus;
  logic    resOverflow;

  logic [RecBits-1:0] gotQ[$];     // Records seen at the DUT output
  logic [RecBits-1:0] heldExp[$];  // Expected records waiting for credit
  int                 heldLine[$];
  bit                 heldDrop[$]; // Record lost to a full queue
  logic               rawBits[$];  // Frame bits before stuffing
  logic               lineBits[$]; // Bits as they go on the bus
  logic               overflowExp;
  int                 errors;
  int                 checks;
  int                 tests;

  canRxTop canRxTop_i (
    .Clock_SP    (Clock_SP),
    .rst         (rst),
    .rxBit       (rxBit),
    .bitStrobe   (bitStrobe),
    .resCredit   (resCredit),
    .resValid    (resValid),
    .resId       (resId),
    .resIde      (resIde),
    .resRtr      (resRtr),
    .resDlc      (resDlc),
    .resData     (resData),
    .resStatus   (resStatus),
    .resOverflow (resOverflow)
  );

  initial
  begin
    Clock_SP = 1'b0;
    forever #20 Clock_SP = ~Clock_SP;  // 40 ns period
  end

  // Consumer model accepts every pulse
  always @(negedge Clock_SP)
  begin
    if (!rst && resValid)
      gotQ.push_back({resId, resIde, resRtr, resDlc, resData, resStatus});
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [14:0] crcStep(input logic [14:0] crc, input logic b);
    logic        feed;
    logic [14:0] nxt;
    begin
      feed = b ^ crc[14];
      nxt  = {crc[13:0], 1'b0};
      if (feed)
        nxt = nxt ^ CanCrcPoly;
      return nxt;
    end
  endfunction

  // Expected record from the frame fields
  function automatic logic [RecBits-1:0] expectRecord(input logic ide, input logic rtr,
      input logic [28:0] id, input logic [3:0] dlc, input logic [63:0] data,
      input logic [1:0] status);
    logic [28:0] fullId;
    logic [63:0] kept;
    int          nBytes;
    begin
      fullId = ide ? id : {id[10:0], 18'd0};  // Base part in upper bits
      nBytes = rtr ? 0 : ((dlc > 8) ? 8 : dlc);
      kept   = '0;
      for (int i = 0; i < nBytes; i++)
        kept[63-8*i -: 8] = data[63-8*i -: 8];
      return {fullId, ide, rtr, dlc, kept, status};
    end
  endfunction

  task automatic compareValue(input string name, input logic [63:0] expV,
                              input logic [63:0] gotV);
    begin
      checks++;
      assert (gotV === expV) else
      begin
        $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expV, gotV);
        errors++;
      end
    end
  endtask

  task automatic checkRecord(input logic [RecBits-1:0] expR, input logic [RecBits-1:0] gotR);
    begin
      compareValue("resStatus", expR[1:0], gotR[1:0]);
      if (expR[1:0] == statusOk)  // Aborted frames carry partial fields
      begin
        compareValue("resId", expR[100:72], gotR[100:72]);
        compareValue("resIde", expR[71], gotR[71]);
        compareValue("resRtr", expR[70], gotR[70]);
        compareValue("resDlc", expR[69:66], gotR[69:66]);
        compareValue("resData", expR[65:2], gotR[65:2]);
      end
    end
  endtask

  task automatic reportTest(input int lineNo, input int errBefore);
    begin
      tests++;
      if (errors == errBefore)
        $display("line %0d: pass", lineNo);
      else
        $display("line %0d: fail, %0d mismatch(es)", lineNo, errors - errBefore);
    end
  endtask

  task automatic driveBit(input logic b);
    int gap;
    begin
      gap = 1 + ($urandom % 3);  // Idle cycles between strobes
      @(posedge Clock_SP);
      rxBit     <= b;
      bitStrobe <= 1'b1;
      @(posedge Clock_SP);
      bitStrobe <= 1'b0;
      repeat (gap) @(posedge Clock_SP);
    end
  endtask

  task automatic grantCredit;
    begin
      @(posedge Clock_SP);
      resCredit <= 1'b1;  // One slot
      @(posedge Clock_SP);
      resCredit <= 1'b0;
    end
  endtask

  task automatic waitRecord(input int limit, output bit found);
    int cycles;
    begin
      cycles = 0;
      while (gotQ.size() == 0 && cycles < limit)
      begin
        @(posedge Clock_SP);
        cycles++;
      end
      found = (gotQ.size() != 0);
    end
  endtask

  task automatic addField(input logic [63:0] value, input int width);
    begin
      for (int i = width - 1; i >= 0; i--)
        rawBits.push_back(value[i]);  // MSB first
    end
  endtask

  // ----------------------------------------
  // Frame serializer
  // ----------------------------------------
  task automatic sendFrame(input logic ide, input logic rtr, input logic [28:0] id,
                           input logic [3:0] dlc, input logic [63:0] data, input int errType);
    logic [14:0] crc;
    logic        prev;
    int          nBytes;
    int          run;
    int          firstStuff;
    begin
      rawBits.delete();
      lineBits.delete();
      nBytes = rtr ? 0 : ((dlc > 8) ? 8 : dlc);
      rawBits.push_back(1'b0);  // SOF
      if (ide)
      begin
        addField(id[28:18], 11);
        addField(2'b11, 2);         // SRR, IDE
        addField(id[17:0], 18);
        addField({rtr, 2'b00}, 3);  // RTR, r1, r0
      end
      else
      begin
        addField(id[10:0], 11);
        addField({rtr, 2'b00}, 3);  // RTR, IDE, r0
      end
      addField(dlc, 4);
      for (int i = 0; i < nBytes; i++)
        addField(data[63-8*i -: 8], 8);
      crc = '0;
      foreach (rawBits[i])
        crc = crcStep(crc, rawBits[i]);  // SOF through data
      if (errType == ErrCrc)
        crc[0] = ~crc[0];
      addField(crc, 15);

      run        = 0;
      prev       = 1'b1;
      firstStuff = -1;
      foreach (rawBits[i])
      begin
        lineBits.push_back(rawBits[i]);
        run  = (rawBits[i] == prev) ? run + 1 : 1;
        prev = rawBits[i];
        if (run == 5)
        begin
          if (firstStuff < 0)
            firstStuff = lineBits.size();
          lineBits.push_back(~prev);  // Stuff bit opens a new run
          prev = ~prev;
          run  = 1;
        end
      end

      if (errType == ErrStuff)
      begin
        checks++;
        assert (firstStuff >= 0) else
        begin
          $display("%0t ns: frame has no stuff bit to corrupt", $time);
          errors++;
        end
        if (firstStuff >= 0)
          lineBits[firstStuff] = ~lineBits[firstStuff];  // Sixth equal bit
      end
      lineBits.push_back(1'b1);  // CRC delimiter
      lineBits.push_back(1'b0);  // ACK slot from other nodes
      lineBits.push_back((errType == ErrAckDelim) ? 1'b0 : 1'b1);
      for (int i = 0; i < 7; i++)
        lineBits.push_back((errType == ErrEofBit && i == 3) ? 1'b0 : 1'b1);
      for (int i = 0; i < IdleBits; i++)
        lineBits.push_back(1'b1);  // Enough for the error wait
      foreach (lineBits[i])
        driveBit(lineBits[i]);
    end
  endtask

  // Deliver the frames sent while credit was withheld
  task automatic releaseHeld;
    logic [RecBits-1:0] gotR;
    bit                 found;
    int                 errBefore;
    begin
      checks++;
      waitRecord(QuietCycles, found);
      assert (!found) else
      begin
        $display("%0t ns: record delivered while credit was withheld", $time);
        errors++;
        gotQ.delete();
      end
      @(negedge Clock_SP);
      compareValue("resOverflow", overflowExp, resOverflow);
      while (heldExp.size() != 0)
      begin
        errBefore = errors;
        grantCredit();
        checks++;
        if (heldDrop[0])
        begin
          waitRecord(QuietCycles, found);
          assert (!found) else
          begin
            $display("%0t ns: record lost to overflow was delivered", $time);
            errors++;
            gotQ.delete();
          end
        end
        else
        begin
          waitRecord(RecordTimeout, found);
          assert (found) else
          begin
            $display("%0t ns: no record within %0d cycles of a credit", $time, RecordTimeout);
            errors++;
          end
          if (found)
          begin
            gotR = gotQ.pop_front();
            checkRecord(heldExp[0], gotR);
          end
          checks++;
          waitRecord(QuietCycles, found);  // One credit, one record
          assert (!found) else
          begin
            $display("%0t ns: more than one record released by a single credit", $time);
            errors++;
            gotQ.delete();
          end
        end
        reportTest(heldLine[0], errBefore);
        void'(heldExp.pop_front());
        void'(heldLine.pop_front());
        void'(heldDrop.pop_front());
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    int                 fd;
    int                 n;
    int                 lineNo;
    int                 errBefore;
    int                 ide;
    int                 rtr;
    int                 dlc;
    int                 errType;
    int                 hold;
    int                 expStat;
    logic [31:0]        idV;
    logic [63:0]        dataV;
    logic [RecBits-1:0] expR;
    logic [RecBits-1:0] gotR;
    string              text;
    bit                 found;

    void'($urandom(66544));
    rst         = 1'b1;
    rxBit       = 1'b1;  // Bus idles recessive
    bitStrobe   = 1'b0;
    resCredit   = 1'b0;
    overflowExp = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    repeat (3) @(posedge Clock_SP);
    rst <= 1'b0;

    fd = $fopen("sim/canFrameInput.txt", "r");
    checks++;
    assert (fd != 0) else
    begin
      $display("cannot open stimulus file sim/canFrameInput.txt");
      errors++;
    end
    if (fd != 0)
    begin
      lineNo = 0;
      while (!$feof(fd))
      begin
        text = "";
        n    = $fgets(text, fd);
        lineNo++;
        if (n > 0 && text.len() > 1 && text.getc(0) != "/")
        begin
          n = $sscanf(text, "%h %h %h %h %h %h %h %h",
                      ide, rtr, idV, dlc, dataV, errType, hold, expStat);
          checks++;
          assert (n == 8) else
          begin
            $display("line %0d of the stimulus file is malformed", lineNo);
            errors++;
          end
          if (n == 8)
          begin
            expR = expectRecord(ide[0], rtr[0], idV[28:0], dlc[3:0], dataV, expStat[1:0]);
            if (hold != 0)
            begin
              heldExp.push_back(expR);  // Credit withheld
              heldLine.push_back(lineNo);
              heldDrop.push_back(hold == 2);
              sendFrame(ide[0], rtr[0], idV[28:0], dlc[3:0], dataV, errType);
              if (hold == 2)
                overflowExp = 1'b1;  // Sticky in the DUT
            end
            else
            begin
              if (heldExp.size() != 0)
                releaseHeld();
              errBefore = errors;
              grantCredit();
              sendFrame(ide[0], rtr[0], idV[28:0], dlc[3:0], dataV, errType);
              waitRecord(RecordTimeout, found);
              checks++;
              assert (found) else
              begin
                $display("%0t ns: no record within %0d cycles", $time, RecordTimeout);
                errors++;
              end
              if (found)
              begin
                gotR = gotQ.pop_front();
                checkRecord(expR, gotR);
              end
              reportTest(lineNo, errBefore);
            end
          end
        end
      end
      $fclose(fd);
      if (heldExp.size() != 0)
        releaseHeld();
    end

    checks++;
    assert (gotQ.size() == 0) else
    begin
      $display("%0d unexpected record(s) left at the output", gotQ.size());
      errors++;
    end
    $display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim/canFrameInput.txt
// ide rtr id dlc data err hold status, all hex; err 0 none 1 stuff 2 crc 3 ackdelim 4 eofbit
// hold 0 credit first, 1 credit withheld, 2 withheld and lost; status 0 ok 1 stuff 2 crc 3 form
0 0 123 2 A55A000000000000 0 0 0 standard data
1 0 1ABCDE12 8 0102030405060708 0 0 0 extended data
0 1 7FF 4 DEADBEEF00000000 0 0 0 remote, data ignored
0 0 055 C 1122334455667788 0 0 0 dlc above 8
0 0 2A5 1 3C00000000000000 2 0 2 crc bit flipped
0 0 2A5 1 3C00000000000000 0 0 0 clean after crc error
0 0 000 1 FF00000000000000 1 0 1 stuff bit missing
0 0 001 1 FF00000000000000 0 0 0 clean after stuff error
1 0 12345678 2 BEEF000000000000 3 0 3 dominant ack delimiter
0 0 3F0 0 0000000000000000 4 0 3 dominant eof bit
0 0 3F1 1 5A00000000000000 0 0 0 clean after form error
0 0 100 1 1100000000000000 0 1 0 held
1 0 00000200 1 2200000000000000 0 1 0 held
0 0 101 1 3300000000000000 0 0 0 releases the held pair
0 0 110 1 4400000000000000 0 1 0 held
0 0 111 1 5500000000000000 0 1 0 held
0 0 112 1 6600000000000000 0 2 0 lost to overflow

//--- tb.f
hw/canProtocolPkg.sv
hw/canRxResultPkg.sv
hw/bitDestuffer.sv
hw/crc15Checker.sv
hw/frameFieldDecoder.sv
hw/frameResultQueue.sv
hw/canRxTop.sv
sim/canRxTb.sv

//--- Bender.yml
package:
  name: can_rx_decoder

sources:
  - files:
      - hw/canProtocolPkg.sv
      - hw/canRxResultPkg.sv
      - hw/bitDestuffer.sv
      - hw/crc15Checker.sv
      - hw/frameFieldDecoder.sv
      - hw/frameResultQueue.sv
      - hw/canRxTop.sv
  - target: simulation
    files:
      - sim/canRxTb.sv
